/* rom_load.f */
source/rom_load_pkg.sv
source/prog_bus_if.sv
source/ioctl_mapper.sv
source/obj_convert.sv
source/dwnld_ctrl.sv
source/rom_load_top.sv
verification/rom_load_checks.sv
verification/rom_load_tb.sv

/* Makefile */
# Verilator flow for the ROM loader.

VERILATOR  ?= verilator
TOP        ?= rom_load_tb
FILELIST   ?= rom_load.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All tests passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Result is decided by the log, not the exit code of the model.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/rom_load_tb.sv */
`timescale 1ns/1ps

module rom_load_tb import rom_load_pkg::*; ();

    // ROM set: all SDRAM bytes plus a few PROM bytes.
    localparam int ROM_BYTES    = int'(PROM_START) + 32;
    localparam int CONV_TIMEOUT = 4 * OBJ_WORDS * (RD_LAT + 5);

    logic               clk;
    logic               arst_n;
    logic               downloading;
    logic [ADDR_W-1:0]  ioctl_addr;
    logic [DATA_W-1:0]  ioctl_data;
    logic               ioctl_wr;
    logic [SDRAM_W-1:0] sdram_dout = '0;
    logic [ADDR_W-1:0]  prog_addr;
    logic [DATA_W-1:0]  prog_data;
    logic [MASK_W-1:0]  prog_mask;
    logic               prog_we;
    logic               prog_rd;
    logic               prom_we;
    logic               dwnld_busy;

    // SDRAM model, one halfword per entry.
    logic [15:0]        mem [int];
    logic [15:0]        half_new;
    logic [SDRAM_W-1:0] rd_pipe [RD_LAT-1];
    int                 chk_errors;
    int                 conv_writes;
    int                 mem_errs;
    int                 other_errs;
    logic               busy_ok;

    rom_load_top i_rom_load_top (.*);

    rom_load_checks i_rom_load_checks (
        .*,
        .conv_state (i_rom_load_top.i_obj_convert.state),
        .errors     (chk_errors)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] read_half(input int h);
        if (mem.exists(h)) begin
            return mem[h];
        end
        return 16'h0000;
    endfunction

    //////////////////////////////////////////////////
    // SDRAM model
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        // Active low mask picks the byte lanes.
        if (prog_we) begin
            half_new = read_half(int'(prog_addr));
            if (!prog_mask[0]) begin
                half_new[7:0] = prog_data;
            end
            if (!prog_mask[1]) begin
                half_new[15:8] = prog_data;
            end
            mem[int'(prog_addr)] = half_new;
        end
        // Read word is the halfword pair, valid RD_LAT cycles on.
        rd_pipe[0] <= prog_rd ? {read_half(int'(prog_addr) + 1), read_half(int'(prog_addr))}
                              : 'x;
        for (int i = 1; i < RD_LAT - 1; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        sdram_dout <= rd_pipe[RD_LAT-2];
    end

    // Host stream, one byte per strobe, random gaps.
    task automatic send_rom();
        for (int b = 0; b < ROM_BYTES; b++) begin
            @(posedge clk);
            ioctl_addr <= ADDR_W'(b);
            ioctl_data <= DATA_W'($urandom);
            ioctl_wr   <= 1'b1;
            if ($urandom % 3 == 0) begin
                @(posedge clk);
                ioctl_wr <= 1'b0;
            end
        end
        @(posedge clk);
        ioctl_wr <= 1'b0;
    endtask

    task automatic wait_busy(input logic level, input int limit, output logic ok);
        int n;
        n = 0;
        while (dwnld_busy !== level && n < limit) begin
            @(posedge clk);
            n++;
        end
        ok = (dwnld_busy === level);
        if (!ok) begin
            other_errs++;
            $display("Timeout: dwnld_busy did not go %0b within %0d cycles", level, limit);
        end
    endtask

    // Whole SDRAM area against the reference image.
    task automatic check_memory();
        logic [15:0] exp;
        for (int h = 0; h < int'(PROM_START) / 2; h++) begin
            exp = {i_rom_load_checks.expected_byte(2 * h + 1),
                   i_rom_load_checks.expected_byte(2 * h)};
            assert (read_half(h) === exp) else begin
                mem_errs++;
                $display("MISMATCH %0t mem[%0h] got %h expected %h",
                         $time, h, read_half(h), exp);
            end
        end
        if (mem.num() != int'(PROM_START) / 2) begin
            other_errs++;
            $display("SDRAM written outside the ROM area, %0d halfwords held", mem.num());
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        void'($urandom(32'h61b2f1f4));
        arst_n <= 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);
        downloading <= 1'b1;
        send_rom();
        repeat (3) @(posedge clk);
        downloading <= 1'b0;
        wait_busy(1'b0, CONV_TIMEOUT, busy_ok);
        if (busy_ok) begin
            // Quiet bus after the end.
            repeat (32) @(posedge clk);
            check_memory();
            if (conv_writes != 4 * OBJ_WORDS) begin
                other_errs++;
                $display("Converter made %0d byte writes, not %0d", conv_writes, 4 * OBJ_WORDS);
            end
        end
        $display("Closing report: %0d checker errors, %0d memory errors, %0d other errors",
                 chk_errors, mem_errs, other_errs);
        if (chk_errors == 0 && mem_errs == 0 && other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verification/rom_load_checks.sv */
`timescale 1ns/1ps

module rom_load_checks import rom_load_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              downloading,
    input  logic [ADDR_W-1:0] ioctl_addr,
    input  logic [DATA_W-1:0] ioctl_data,
    input  logic              ioctl_wr,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [DATA_W-1:0] prog_data,
    input  logic [MASK_W-1:0] prog_mask,
    input  logic              prog_we,
    input  logic              prog_rd,
    input  logic              prom_we,
    input  logic              dwnld_busy,
    input  conv_state_t       conv_state,
    output int                errors,
    output int                conv_writes
);

    // Object region in byte addresses.
    localparam int OBJ_BYTE0 = 2 * int'(OBJ_START);
    localparam int OBJ_BYTES = 4 * OBJ_WORDS;

    // Downloaded SDRAM bytes, by byte address.
    logic [DATA_W-1:0] shadow [int];
    logic              sdram_byte;
    logic              prom_byte;
    // Host strobes delayed by one and two cycles.
    logic [1:0]        wr_q;
    logic [1:0]        prom_q;
    logic [ADDR_W-1:0] addr_q [2];
    logic [DATA_W-1:0] data_q [2];

    assign sdram_byte = ioctl_wr && downloading && (ioctl_addr < PROM_START);
    assign prom_byte  = ioctl_wr && downloading && (ioctl_addr >= PROM_START);

    // Final SDRAM content of byte address b.
    function automatic logic [DATA_W-1:0] expected_byte(input int b);
        int src;
        src = b;
        if (b >= OBJ_BYTE0 && b < OBJ_BYTE0 + OBJ_BYTES) begin
            // Byte j of a word comes from byte 3-j, nibbles swapped.
            src = b + 3 - 2 * ((b - OBJ_BYTE0) % 4);
            return {shadow[src][3:0], shadow[src][7:4]};
        end
        return shadow[src];
    endfunction

    task automatic report_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // Host byte tracking and bus compares
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!arst_n) begin
            wr_q        <= '0;
            prom_q      <= '0;
            conv_writes <= 0;
            // Everything idle while reset is held.
            compare_value("prog_we", 32'(prog_we), 32'd0);
            compare_value("prom_we", 32'(prom_we), 32'd0);
            compare_value("prog_rd", 32'(prog_rd), 32'd0);
            compare_value("dwnld_busy", 32'(dwnld_busy), 32'd0);
            compare_value("prog_mask", 32'(prog_mask), 32'(MASK_NONE));
        end else begin
            wr_q      <= {wr_q[0], sdram_byte};
            prom_q    <= {prom_q[0], prom_byte};
            addr_q[0] <= ioctl_addr;
            addr_q[1] <= addr_q[0];
            data_q[0] <= ioctl_data;
            data_q[1] <= data_q[0];
            if (sdram_byte) begin
                shadow[int'(ioctl_addr)] = ioctl_data;
            end
            // Converter write cycles, for coverage.
            if (conv_state == CONV_WRITE) begin
                conv_writes <= conv_writes + 1;
            end
            // SDRAM byte lands two cycles after the strobe.
            if (wr_q[1]) begin
                compare_value("prog_we", 32'(prog_we), 32'd1);
                compare_value("prog_addr", 32'(prog_addr), 32'(addr_q[1] >> 1));
                compare_value("prog_data", 32'(prog_data), 32'(data_q[1]));
                compare_value("prog_mask", 32'(prog_mask),
                              addr_q[1][0] ? 32'(MASK_HI) : 32'(MASK_LO));
            end
            // PROM byte shows its offset, with no SDRAM write.
            if (prom_q[1]) begin
                compare_value("prog_we", 32'(prog_we), 32'd0);
                compare_value("prog_addr", 32'(prog_addr), 32'(addr_q[1] - PROM_START));
                compare_value("prog_data", 32'(prog_data), 32'(data_q[1]));
            end
        end
    end

    //////////////////////////////////////////////////
    // Protocol properties
    //////////////////////////////////////////////////

    a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
        downloading |=> dwnld_busy)
        else report_failure("dwnld_busy did not follow downloading");

    a_prom_we: assert property (@(posedge clk) disable iff (!arst_n)
        prom_byte |=> prom_we)
        else report_failure("prom_we missing after a PROM byte");

    // Busy covers the whole conversion.
    a_busy_conv: assert property (@(posedge clk) disable iff (!arst_n)
        (conv_state != CONV_IDLE) |-> dwnld_busy)
        else report_failure("dwnld_busy low during conversion");

    a_busy_end: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(dwnld_busy) |-> ($past(conv_state) == CONV_DONE))
        else report_failure("dwnld_busy fell before the conversion finished");

    a_quiet_bus: assert property (@(posedge clk) disable iff (!arst_n)
        !dwnld_busy |-> (!prog_we && !prog_rd))
        else report_failure("program bus active while not busy");

    a_idle_mask: assert property (@(posedge clk) disable iff (!arst_n)
        !prog_we |-> (prog_mask == MASK_NONE))
        else report_failure("prog_mask not idle without a write");

endmodule

/* source/rom_load_top.sv */
`timescale 1ns/1ps

module rom_load_top import rom_load_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               downloading,
    input  logic [ADDR_W-1:0]  ioctl_addr,
    input  logic [DATA_W-1:0]  ioctl_data,
    input  logic               ioctl_wr,
    input  logic [SDRAM_W-1:0] sdram_dout,
    output logic [ADDR_W-1:0]  prog_addr,
    output logic [DATA_W-1:0]  prog_data,
    output logic [MASK_W-1:0]  prog_mask,
    output logic               prog_we,
    output logic               prog_rd,
    output logic               prom_we,
    output logic               dwnld_busy
);

    // Conversion request and completion.
    logic convert;
    logic conv_done;

    // Download and converter sources.
    prog_bus_if dl_bus ();
    prog_bus_if cv_bus ();

    //////////////////////////////////////////////////
    // Datapath blocks
    //////////////////////////////////////////////////

    ioctl_mapper i_ioctl_mapper (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .bus         (dl_bus),
        .prom_we     (prom_we)
    );

    obj_convert i_obj_convert (
        .clk        (clk),
        .arst_n     (arst_n),
        .convert    (convert),
        .sdram_dout (sdram_dout),
        .bus        (cv_bus),
        .prog_rd    (prog_rd),
        .conv_done  (conv_done)
    );

    // Bus select and busy flag.
    dwnld_ctrl i_dwnld_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .dl_bus      (dl_bus),
        .cv_bus      (cv_bus),
        .conv_done   (conv_done),
        .convert     (convert),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .dwnld_busy  (dwnld_busy)
    );

endmodule

/* source/dwnld_ctrl.sv */
`timescale 1ns/1ps

module dwnld_ctrl import rom_load_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              downloading,
    prog_bus_if.sink          dl_bus,
    prog_bus_if.sink          cv_bus,
    input  logic              conv_done,
    output logic              convert,
    output logic [ADDR_W-1:0] prog_addr,
    output logic [DATA_W-1:0] prog_data,
    output logic [MASK_W-1:0] prog_mask,
    output logic              prog_we,
    output logic              dwnld_busy
);

    // Downloading, one cycle late.
    logic dl_last;
    logic dl_fall;
    // Download path owns the bus.
    logic dl_sel;

    assign dl_fall = dl_last && !downloading;
    // Extra cycle lets the final mapper write through.
    assign dl_sel  = downloading || dl_last;

    //////////////////////////////////////////////////
    // Phase control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dl_last    <= 1'b0;
            convert    <= 1'b0;
            dwnld_busy <= 1'b0;
        end else begin
            dl_last <= downloading;
            // Conversion starts once the download ends.
            if (dl_fall) begin
                convert <= 1'b1;
            end else if (conv_done) begin
                convert <= 1'b0;
            end
            if (downloading) begin
                dwnld_busy <= 1'b1;
            end else if (conv_done) begin
                dwnld_busy <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Program bus register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we   <= 1'b0;
            prog_mask <= MASK_NONE;
        end else if (dl_sel) begin
            prog_we   <= dl_bus.we;
            prog_mask <= dl_bus.mask;
        end else if (convert) begin
            prog_we   <= cv_bus.we;
            prog_mask <= cv_bus.mask;
        end else begin
            // Quiet bus.
            prog_we   <= 1'b0;
            prog_mask <= MASK_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (dl_sel) begin
            prog_addr <= dl_bus.addr;
            prog_data <= dl_bus.data;
        end else if (convert) begin
            prog_addr <= cv_bus.addr;
            prog_data <= cv_bus.data;
        end
    end

    // Host must not restart a download mid conversion.
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(convert && downloading)
    ) else $error("dwnld_ctrl: convert high while downloading");

endmodule

/* source/obj_convert.sv */
`timescale 1ns/1ps

module obj_convert import rom_load_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               convert,
    input  logic [SDRAM_W-1:0] sdram_dout,
    prog_bus_if.source         bus,
    output logic               prog_rd,
    output logic               conv_done
);

    conv_state_t           state;
    // Word being converted.
    logic [WORD_CNT_W-1:0] word_cnt;
    // Cycles spent waiting for read data.
    logic [LAT_CNT_W-1:0]  lat_cnt;
    // Byte of the word being written.
    logic [1:0]            byte_idx;
    // Re-ordered word, held for bytes 1 to 3.
    logic [SDRAM_W-1:0]    word_buf;
    // Re-ordered form of the live read data.
    logic [SDRAM_W-1:0]    reordered;
    // Halfword address of the current word.
    logic [ADDR_W-1:0]     word_addr;
    logic                  last_word;
    // Read data is valid this cycle.
    logic                  capture;

    assign word_addr = OBJ_START + ADDR_W'({word_cnt, 1'b0});
    assign last_word = word_cnt == WORD_CNT_W'(OBJ_WORDS - 1);
    assign capture   = (state == CONV_WRITE) && (byte_idx == 2'd0);
    assign conv_done = state == CONV_DONE;

    // Byte j takes byte 3-j with its nibbles swapped.
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            reordered[8*j +: 8] = {sdram_dout[8*(3-j) +: 4], sdram_dout[8*(3-j)+4 +: 4]};
        end
    end

    //////////////////////////////////////////////////
    // Converter FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= CONV_IDLE;
            word_cnt <= '0;
            lat_cnt  <= '0;
            byte_idx <= '0;
            prog_rd  <= 1'b0;
        end else begin
            // Read strobe trails the address by one cycle.
            prog_rd <= state == CONV_READ;
            case (state)
                CONV_IDLE: begin
                    word_cnt <= '0;
                    if (convert) begin
                        state <= CONV_READ;
                    end
                end
                CONV_READ: begin
                    lat_cnt <= LAT_CNT_W'(1);
                    state   <= CONV_WAIT;
                end
                CONV_WAIT: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (lat_cnt == LAT_CNT_W'(RD_LAT)) begin
                        byte_idx <= '0;
                        state    <= CONV_WRITE;
                    end
                end
                CONV_WRITE: begin
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == 2'd3) begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= last_word ? CONV_DONE : CONV_READ;
                    end
                end
                CONV_DONE: begin
                    state <= CONV_IDLE;
                end
                default: begin
                    state <= CONV_IDLE;
                end
            endcase
        end
    end

    // Holds the word for the last three byte writes.
    always_ff @(posedge clk) begin
        if (capture) begin
            word_buf <= reordered;
        end
    end

    //////////////////////////////////////////////////
    // Program bus drive
    //////////////////////////////////////////////////

    always_comb begin
        bus.we = state == CONV_WRITE;
        // First byte comes straight from the SDRAM.
        bus.data = capture ? reordered[7:0] : word_buf[8*byte_idx +: 8];
        if (state == CONV_WRITE) begin
            bus.addr = word_addr + ADDR_W'(byte_idx[1]);
            bus.mask = byte_idx[0] ? MASK_HI : MASK_LO;
        end else begin
            // Read address outside write cycles.
            bus.addr = word_addr;
            bus.mask = MASK_NONE;
        end
    end

    // Reads and writes never share a cycle.
    a_rd_we_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(prog_rd && bus.we)
    ) else $error("obj_convert: read and write in one cycle");

    a_word_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        word_cnt <= WORD_CNT_W'(OBJ_WORDS)
    ) else $error("obj_convert: word counter out of range");

endmodule

/* source/ioctl_mapper.sv */
`timescale 1ns/1ps

module ioctl_mapper import rom_load_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              downloading,
    input  logic [ADDR_W-1:0] ioctl_addr,
    input  logic [DATA_W-1:0] ioctl_data,
    input  logic              ioctl_wr,
    prog_bus_if.source        bus,
    output logic              prom_we
);

    // Qualified host strobe.
    logic              byte_wr;
    // Byte belongs to the PROM region.
    logic              in_prom;
    // Byte offset inside the PROM region.
    logic [ADDR_W-1:0] prom_offset;
    // Halfword address for SDRAM bytes.
    logic [ADDR_W-1:0] half_addr;

    assign byte_wr     = ioctl_wr && downloading;
    assign in_prom     = ioctl_addr >= PROM_START;
    assign prom_offset = ioctl_addr - PROM_START;
    assign half_addr   = {1'b0, ioctl_addr[ADDR_W-1:1]};

    //////////////////////////////////////////////////
    // Strobes and byte mask
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.we   <= 1'b0;
            bus.mask <= MASK_NONE;
            prom_we  <= 1'b0;
        end else begin
            // Exactly one destination per byte.
            bus.we  <= byte_wr && !in_prom;
            prom_we <= byte_wr && in_prom;
            if (byte_wr && !in_prom) begin
                // Even bytes go low, odd bytes go high.
                if (ioctl_addr[0]) begin
                    bus.mask <= MASK_HI;
                end else begin
                    bus.mask <= MASK_LO;
                end
            end else begin
                // Idle bus keeps both bytes off.
                bus.mask <= MASK_NONE;
            end
        end
    end

    //////////////////////////////////////////////////
    // Address and data
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (byte_wr) begin
            if (in_prom) begin
                bus.addr <= prom_offset;
            end else begin
                bus.addr <= half_addr;
            end
            bus.data <= ioctl_data;
        end
    end

    // SDRAM and PROM writes are exclusive.
    a_single_dest: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(bus.we && prom_we)
    ) else $error("ioctl_mapper: SDRAM and PROM write in one cycle");

endmodule

/* source/prog_bus_if.sv */
`timescale 1ns/1ps

interface prog_bus_if import rom_load_pkg::*; ();

    // Halfword address, or PROM offset.
    logic [ADDR_W-1:0] addr;
    // Byte to write.
    logic [DATA_W-1:0] data;
    // Active low byte enables.
    logic [MASK_W-1:0] mask;
    // One-cycle write strobe.
    logic              we;

    modport source (
        output addr,
        output data,
        output mask,
        output we
    );

    modport sink (
        input addr,
        input data,
        input mask,
        input we
    );

endinterface

/* source/rom_load_pkg.sv */
package rom_load_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    // Byte and halfword addresses share one width.
    localparam int ADDR_W  = 22;
    // One download byte.
    localparam int DATA_W  = 8;
    // One SDRAM read word, a halfword pair.
    localparam int SDRAM_W = 32;
    // Byte mask of a halfword.
    localparam int MASK_W  = 2;

    // Active low byte enables.
    localparam logic [MASK_W-1:0] MASK_NONE = 2'b11;
    localparam logic [MASK_W-1:0] MASK_LO   = 2'b10;
    localparam logic [MASK_W-1:0] MASK_HI   = 2'b01;

    //////////////////////////////////////////////////
    // Address map and timing
    //////////////////////////////////////////////////

    // First byte routed to the colour PROMs.
    localparam logic [ADDR_W-1:0] PROM_START = 22'h000200;
    // Object graphics base, in halfwords.
    localparam logic [ADDR_W-1:0] OBJ_START  = 22'h000000;
    // 32-bit words in the object region.
    localparam int OBJ_WORDS = 64;
    // Cycles from prog_rd to valid sdram_dout.
    localparam int RD_LAT    = 2;

    // Counter widths for the converter.
    localparam int WORD_CNT_W = $clog2(OBJ_WORDS + 1);
    localparam int LAT_CNT_W  = $clog2(RD_LAT + 1);

    // Converter FSM states.
    typedef enum logic [2:0] {
        CONV_IDLE,
        CONV_READ,
        CONV_WAIT,
        CONV_WRITE,
        CONV_DONE
    } conv_state_t;

endpackage
